// ==== sq_subsys.f ====
sq_pkg.sv
sq_store_queue.sv
sq_store_writer.sv
sq_csr.sv
sq_top.sv
sq_assertions.sv
sq_tb.sv

// ==== Makefile ====
# Verilator build and run of the store-commit testbench

TOP := sq_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f sq_subsys.f
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "TESTBENCH FAILED" sim.log || ! grep -q "TESTBENCH PASSED" sim.log; then \
		echo "Simulation failed"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf obj_dir sim.log

// ==== sq_tb.sv ====
/*
 * Store-commit subsystem testbench
 * Random allocation, retirement and flush traffic against a behavioral
 * Wishbone memory, checked against an in-order store model
 */
`timescale 1ns/1ns

module sq_tb;
    import sq_pkg::*;

    localparam int SQ_DEPTH = 8;
    localparam int N_OPS = 400;
    localparam int N_STORES = N_OPS + SQ_DEPTH;
    localparam int TIMEOUT_CYCLES = 20 * N_STORES + 500;
    localparam int MEM_WORDS = 64;
    localparam int unsigned SEED = 88;

    typedef struct packed {
        lsu_func_t func;
        rob_tag_t  tag;
        addr_t     addr;
        data_t     data;
    } store_t;

    logic      clk;
    logic      n_rst;
    logic      i_flush;
    logic      i_alloc_en;
    lsu_func_t i_alloc_func;
    rob_tag_t  i_alloc_tag;
    addr_t     i_alloc_addr;
    data_t     i_alloc_data;
    logic      o_full;
    logic      i_rob_retire_en;
    rob_tag_t  i_rob_retire_tag;
    logic      o_rob_retire_ack;
    logic      o_mem_cyc;
    logic      o_mem_stb;
    logic      o_mem_we;
    addr_t     o_mem_adr;
    byte_sel_t o_mem_sel;
    data_t     o_mem_dat;
    logic      i_mem_ack;
    logic      i_mem_err;
    logic      i_cfg_cyc;
    logic      i_cfg_stb;
    logic      i_cfg_we;
    csr_addr_t i_cfg_adr;
    data_t     i_cfg_dat;
    logic      o_cfg_ack;
    data_t     o_cfg_dat;

    // Stores allocated but not retired, and retired stores in commit order
    store_t      pending_q[$];
    store_t      commit_q[$];
    logic [7:0]  model_mem [4*MEM_WORDS];
    data_t       slave_mem [MEM_WORDS];
    int unsigned stim_state;
    int unsigned mem_state;
    int          cycle_count = 0;
    count_t      model_commits = '0;
    count_t      model_retries = '0;
    count_t      retire_count = '0;
    count_t      ack_count = '0;
    rob_tag_t    next_tag = '0;

    sq_top #(.SQ_DEPTH(SQ_DEPTH)) u_dut (.*);

    function automatic int unsigned lcg_next(inout int unsigned state);
        state = state * 32'd1664525 + 32'd1013904223;
        return state;
    endfunction

    // Upper bits of the generator have the longer period
    function automatic int unsigned pick_below(inout int unsigned state, input int unsigned n);
        int unsigned r;
        r = lcg_next(state);
        return (r >> 16) % n;
    endfunction

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_data(input string name, input data_t exp, input data_t act);
        if (act !== exp) begin
            fail_run($sformatf("ERROR %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        if (act !== exp) begin
            fail_run($sformatf("ERROR %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_sel(input string name, input byte_sel_t exp, input byte_sel_t act);
        if (act !== exp) begin
            fail_run($sformatf("ERROR %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    task automatic check_count(input string name, input count_t exp, input count_t act);
        if (act !== exp) begin
            fail_run($sformatf("ERROR %s: expected %0d, actual %0d", name, exp, act));
        end
    endtask

    task automatic check_flag(input string name, input bit exp, input bit act);
        if (act !== exp) begin
            fail_run($sformatf("ERROR %s: expected %0b, actual %0b", name, exp, act));
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        forever begin
            @(posedge clk);
            cycle_count++;
            if (cycle_count >= TIMEOUT_CYCLES) begin
                fail_run($sformatf("Timeout: the run did not end within %0d cycles",
                                   TIMEOUT_CYCLES));
            end
        end
    end

    // The ROB acknowledgement is counted away from the clock edge
    always @(negedge clk) begin
        if (n_rst && o_rob_retire_ack) begin
            ack_count++;
        end
    end

    // Writes one store into the byte model with its lowest byte at the store address
    task automatic apply_model(input store_t st);
        int nbytes;
        nbytes = 1 << st.func;
        for (int j = 0; j < nbytes; j++) begin
            model_mem[st.addr[7:0] + 8'(j)] = st.data[8*j +: 8];
        end
    endtask

    // Behavioral Wishbone classic memory with random wait states and errors
    initial begin : mem_slave
        store_t    st;
        byte_sel_t exp_sel;
        data_t     exp_word;
        data_t     mask;
        addr_t     adr;
        byte_sel_t sel;
        data_t     dat;
        int        waits;
        bit        err;
        i_mem_ack = 1'b0;
        i_mem_err = 1'b0;
        forever begin
            next_cycle();
            if (n_rst && o_mem_cyc && o_mem_stb) begin
                if (commit_q.size() == 0) begin
                    fail_run("A bus write started with no retired store waiting to commit");
                end
                st = commit_q[0];
                adr = o_mem_adr;
                sel = o_mem_sel;
                dat = o_mem_dat;
                // Lanes follow from the store size and the address offset
                exp_sel  = byte_sel_t'(((4'd1 << (1 << st.func)) - 4'd1) << st.addr[1:0]);
                exp_word = st.data << {st.addr[1:0], 3'b000};
                for (int k = 0; k < 4; k++) begin
                    mask[8*k +: 8] = {8{exp_sel[k]}};
                end
                check_flag("bus write enable", 1'b1, o_mem_we);
                check_addr("bus address", {st.addr[31:2], 2'b00}, adr);
                check_sel("bus byte select", exp_sel, sel);
                check_data("bus lane data", exp_word & mask, dat & mask);
                waits = int'(pick_below(mem_state, 4));
                repeat (waits) begin
                    next_cycle();
                end
                err = (pick_below(mem_state, 8) == 0);
                i_mem_ack = !err;
                i_mem_err = err;
                next_cycle();
                i_mem_ack = 1'b0;
                i_mem_err = 1'b0;
                if (err) begin
                    model_retries++;
                end else begin
                    for (int k = 0; k < 4; k++) begin
                        if (sel[k]) begin
                            slave_mem[adr[7:2]][8*k +: 8] = dat[8*k +: 8];
                        end
                    end
                    apply_model(st);
                    void'(commit_q.pop_front());
                    model_commits++;
                end
            end
        end
    end

    task automatic alloc_random();
        store_t      st;
        int unsigned off;
        int unsigned r1;
        int unsigned r2;
        st.func = lsu_func_t'(pick_below(stim_state, 3));
        case (st.func)
            LSU_FUNC_SB: off = pick_below(stim_state, 4);
            LSU_FUNC_SH: off = 2 * pick_below(stim_state, 2);
            default:     off = 0;
        endcase
        st.addr = addr_t'(pick_below(stim_state, MEM_WORDS) * 4 + off);
        r1 = lcg_next(stim_state);
        r2 = lcg_next(stim_state);
        st.data = {r1[31:16], r2[31:16]};
        st.tag = next_tag;
        next_tag++;
        i_alloc_en   = 1'b1;
        i_alloc_func = st.func;
        i_alloc_tag  = st.tag;
        i_alloc_addr = st.addr;
        i_alloc_data = st.data;
        next_cycle();
        i_alloc_en = 1'b0;
        pending_q.push_back(st);
    endtask

    // The ROB retires in program order and holds the request until the ack
    task automatic retire_oldest();
        store_t st;
        st = pending_q.pop_front();
        commit_q.push_back(st);
        retire_count++;
        i_rob_retire_en  = 1'b1;
        i_rob_retire_tag = st.tag;
        do begin
            next_cycle();
        end while (!o_rob_retire_ack);
        i_rob_retire_en = 1'b0;
    endtask

    // Every pending store frees its entry, so the queue cannot stay full
    task automatic flush_pending();
        i_flush = 1'b1;
        next_cycle();
        i_flush = 1'b0;
        pending_q.delete();
        check_flag("not full after flush", 1'b0, o_full);
    endtask

    task automatic cfg_access(input bit we, input csr_addr_t adr, input data_t wdat,
                              output data_t rdat);
        i_cfg_cyc = 1'b1;
        i_cfg_stb = 1'b1;
        i_cfg_we  = we;
        i_cfg_adr = adr;
        i_cfg_dat = wdat;
        do begin
            next_cycle();
        end while (!o_cfg_ack);
        rdat = o_cfg_dat;
        i_cfg_cyc = 1'b0;
        i_cfg_stb = 1'b0;
        i_cfg_we  = 1'b0;
    endtask

    task automatic drain_queue();
        while (pending_q.size() > 0) begin
            retire_oldest();
        end
        while (commit_q.size() > 0) begin
            next_cycle();
        end
        // The entry and the counters update one edge after the bus cycle
        next_cycle();
    endtask

    initial begin
        data_t       rd;
        int unsigned op_sel;
        data_t       exp;
        n_rst = 1'b0;
        i_flush = 1'b0;
        i_alloc_en = 1'b0;
        i_alloc_func = '0;
        i_alloc_tag = '0;
        i_alloc_addr = '0;
        i_alloc_data = '0;
        i_rob_retire_en = 1'b0;
        i_rob_retire_tag = '0;
        i_cfg_cyc = 1'b0;
        i_cfg_stb = 1'b0;
        i_cfg_we = 1'b0;
        i_cfg_adr = '0;
        i_cfg_dat = '0;
        stim_state = SEED;
        mem_state = lcg_next(stim_state);
        for (int w = 0; w < MEM_WORDS; w++) begin
            slave_mem[w] = 32'hc3a5_0000 | data_t'(w * 4);
            for (int k = 0; k < 4; k++) begin
                model_mem[4*w + k] = slave_mem[w][8*k +: 8];
            end
        end
        repeat (4) @(posedge clk);
        #1;
        n_rst = 1'b1;

        // Mixed traffic with retries from bus errors and occasional flushes
        for (int op = 0; op < N_OPS; op++) begin
            op_sel = pick_below(stim_state, 16);
            if (op_sel < 8 && !o_full) begin
                alloc_random();
            end else if (op_sel < 14 && pending_q.size() > 0) begin
                retire_oldest();
            end else if (op_sel == 15 && pending_q.size() > 0) begin
                flush_pending();
            end else begin
                next_cycle();
            end
        end
        drain_queue();

        // Fill the queue with commits held back, then let them go
        cfg_access(1'b1, CSR_CTRL, 32'h0, rd);
        cfg_access(1'b0, CSR_CTRL, '0, rd);
        check_data("control register disabled", 32'h0, rd);
        for (int i = 0; i < SQ_DEPTH; i++) begin
            alloc_random();
        end
        check_flag("full after allocations", 1'b1, o_full);
        fork
            retire_oldest();
            begin
                repeat (20) begin
                    next_cycle();
                    check_flag("bus idle with commits disabled", 1'b0, o_mem_cyc);
                end
                cfg_access(1'b1, CSR_CTRL, 32'h1, rd);
            end
        join
        drain_queue();
        check_flag("full after drain", 1'b0, o_full);

        cfg_access(1'b0, CSR_COMMITS, '0, rd);
        check_count("commit counter", model_commits, rd);
        cfg_access(1'b0, CSR_RETRIES, '0, rd);
        check_count("retry counter", model_retries, rd);
        check_flag("bus errors seen", 1'b1, model_retries != 0);
        cfg_access(1'b1, CSR_CTRL, 32'h3, rd);
        cfg_access(1'b0, CSR_COMMITS, '0, rd);
        check_count("commit counter after clear", '0, rd);
        cfg_access(1'b0, CSR_RETRIES, '0, rd);
        check_count("retry counter after clear", '0, rd);
        cfg_access(1'b0, CSR_CTRL, '0, rd);
        check_data("control register", 32'h1, rd);
        cfg_access(1'b0, 2'd3, '0, rd);
        check_data("reserved register", 32'h0, rd);
        check_count("rob ack count", retire_count, ack_count);

        for (int w = 0; w < MEM_WORDS; w++) begin
            exp = {model_mem[4*w + 3], model_mem[4*w + 2], model_mem[4*w + 1], model_mem[4*w]};
            check_data($sformatf("memory word %0d", w), exp, slave_mem[w]);
        end

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== sq_assertions.sv ====
/*
 * Store-commit protocol assertions
 * Watches the memory bus, the allocation port and the ROB handshake
 */
`timescale 1ns/1ns

module sq_assertions (
    input logic clk,
    input logic n_rst,
    input logic i_alloc_en,
    input logic i_full,
    input logic i_retire_ack,
    input logic i_mem_cyc,
    input logic i_mem_stb,
    input logic i_mem_ack,
    input logic i_mem_err
);

    // A strobe only exists inside a bus cycle
    stb_in_cyc: assert property (@(posedge clk) disable iff (!n_rst)
        i_mem_stb |-> i_mem_cyc)
        else $error("memory strobe high outside a bus cycle");

    // Classic cycles keep the strobe until the slave answers
    stb_held: assert property (@(posedge clk) disable iff (!n_rst)
        i_mem_stb && !(i_mem_ack || i_mem_err) |=> i_mem_stb)
        else $error("memory strobe dropped before ack or err");

    no_alloc_full: assert property (@(posedge clk) disable iff (!n_rst)
        i_alloc_en |-> !i_full)
        else $error("store allocated while the queue is full");

    // Each retire request is released by exactly one cycle of ack
    ack_single: assert property (@(posedge clk) disable iff (!n_rst)
        i_retire_ack |=> !i_retire_ack)
        else $error("ROB retire ack longer than one cycle");

endmodule

bind sq_top sq_assertions u_assertions (
    .clk          (clk),
    .n_rst        (n_rst),
    .i_alloc_en   (i_alloc_en),
    .i_full       (o_full),
    .i_retire_ack (o_rob_retire_ack),
    .i_mem_cyc    (o_mem_cyc),
    .i_mem_stb    (o_mem_stb),
    .i_mem_ack    (i_mem_ack),
    .i_mem_err    (i_mem_err)
);

// ==== sq_top.sv ====
/*
 * Store-commit subsystem top level
 * Connects the store queue, the bus writer and the configuration block
 */
`timescale 1ns/1ns

module sq_top #(
    parameter int SQ_DEPTH = 8
) (
    input  logic              clk,
    input  logic              n_rst,
    input  logic              i_flush,

    input  logic              i_alloc_en,
    input  sq_pkg::lsu_func_t i_alloc_func,
    input  sq_pkg::rob_tag_t  i_alloc_tag,
    input  sq_pkg::addr_t     i_alloc_addr,
    input  sq_pkg::data_t     i_alloc_data,
    output logic              o_full,

    input  logic              i_rob_retire_en,
    input  sq_pkg::rob_tag_t  i_rob_retire_tag,
    output logic              o_rob_retire_ack,

    output logic              o_mem_cyc,
    output logic              o_mem_stb,
    output logic              o_mem_we,
    output sq_pkg::addr_t     o_mem_adr,
    output sq_pkg::byte_sel_t o_mem_sel,
    output sq_pkg::data_t     o_mem_dat,
    input  logic              i_mem_ack,
    input  logic              i_mem_err,

    input  logic              i_cfg_cyc,
    input  logic              i_cfg_stb,
    input  logic              i_cfg_we,
    input  sq_pkg::csr_addr_t i_cfg_adr,
    input  sq_pkg::data_t     i_cfg_dat,
    output logic              o_cfg_ack,
    output sq_pkg::data_t     o_cfg_dat
);
    import sq_pkg::*;

    // Launch path from queue to writer
    logic                launch_en;
    logic [SQ_DEPTH-1:0] launch_sel;
    lsu_func_t           launch_func;
    addr_t               launch_addr;
    data_t               launch_data;
    logic                launch_stall;

    // Result path from writer back to queue and counters
    logic                upd_en;
    logic [SQ_DEPTH-1:0] upd_sel;
    logic                upd_retry;

    logic                commit_en;

    sq_store_queue #(
        .SQ_DEPTH (SQ_DEPTH)
    ) u_queue (
        .clk              (clk),
        .n_rst            (n_rst),
        .i_flush          (i_flush),
        .i_alloc_en       (i_alloc_en),
        .i_alloc_func     (i_alloc_func),
        .i_alloc_tag      (i_alloc_tag),
        .i_alloc_addr     (i_alloc_addr),
        .i_alloc_data     (i_alloc_data),
        .o_full           (o_full),
        .i_rob_retire_en  (i_rob_retire_en),
        .i_rob_retire_tag (i_rob_retire_tag),
        .o_rob_retire_ack (o_rob_retire_ack),
        .i_launch_stall   (launch_stall),
        .o_launch_en      (launch_en),
        .o_launch_sel     (launch_sel),
        .o_launch_func    (launch_func),
        .o_launch_addr    (launch_addr),
        .o_launch_data    (launch_data),
        .i_upd_en         (upd_en),
        .i_upd_sel        (upd_sel),
        .i_upd_retry      (upd_retry)
    );

    sq_store_writer #(
        .SQ_DEPTH (SQ_DEPTH)
    ) u_writer (
        .clk            (clk),
        .n_rst          (n_rst),
        .i_launch_en    (launch_en),
        .i_launch_sel   (launch_sel),
        .i_launch_func  (launch_func),
        .i_launch_addr  (launch_addr),
        .i_launch_data  (launch_data),
        .o_launch_stall (launch_stall),
        .i_commit_en    (commit_en),
        .o_upd_en       (upd_en),
        .o_upd_sel      (upd_sel),
        .o_upd_retry    (upd_retry),
        .o_mem_cyc      (o_mem_cyc),
        .o_mem_stb      (o_mem_stb),
        .o_mem_we       (o_mem_we),
        .o_mem_adr      (o_mem_adr),
        .o_mem_sel      (o_mem_sel),
        .o_mem_dat      (o_mem_dat),
        .i_mem_ack      (i_mem_ack),
        .i_mem_err      (i_mem_err)
    );

    sq_csr u_csr (
        .clk         (clk),
        .n_rst       (n_rst),
        .i_cfg_cyc   (i_cfg_cyc),
        .i_cfg_stb   (i_cfg_stb),
        .i_cfg_we    (i_cfg_we),
        .i_cfg_adr   (i_cfg_adr),
        .i_cfg_dat   (i_cfg_dat),
        .o_cfg_ack   (o_cfg_ack),
        .o_cfg_dat   (o_cfg_dat),
        .i_upd_en    (upd_en),
        .i_upd_retry (upd_retry),
        .o_commit_en (commit_en)
    );

endmodule

// ==== sq_csr.sv ====
/*
 * Store-commit configuration block
 * Wishbone classic slave with the commit-enable bit and counters of
 * committed and retried stores
 */
`timescale 1ns/1ns

module sq_csr (
    input  logic              clk,
    input  logic              n_rst,

    input  logic              i_cfg_cyc,
    input  logic              i_cfg_stb,
    input  logic              i_cfg_we,
    input  sq_pkg::csr_addr_t i_cfg_adr,
    input  sq_pkg::data_t     i_cfg_dat,
    output logic              o_cfg_ack,
    output sq_pkg::data_t     o_cfg_dat,

    input  logic              i_upd_en,
    input  logic              i_upd_retry,

    output logic              o_commit_en
);
    import sq_pkg::*;

    logic   access;
    logic   wr_ctrl;
    logic   clr_counts;
    count_t commits_q;
    count_t retries_q;
    data_t  rd_data;

    // The ack cycle itself is not a new access, so every strobe gets one pulse
    assign access     = i_cfg_cyc & i_cfg_stb & ~o_cfg_ack;
    assign wr_ctrl    = access & i_cfg_we & (i_cfg_adr == CSR_CTRL);
    assign clr_counts = wr_ctrl & i_cfg_dat[1];

    always_comb begin
        case (i_cfg_adr)
            CSR_CTRL:    rd_data = data_t'(o_commit_en);
            CSR_COMMITS: rd_data = commits_q;
            CSR_RETRIES: rd_data = retries_q;
            default:     rd_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            o_cfg_ack <= 1'b0;
        end else begin
            o_cfg_ack <= access;
        end
    end

    always_ff @(posedge clk) begin
        if (access) begin
            o_cfg_dat <= rd_data;
        end
    end

    // Commits are enabled out of reset
    always_ff @(posedge clk) begin
        if (!n_rst) begin
            o_commit_en <= 1'b1;
        end else if (wr_ctrl) begin
            o_commit_en <= i_cfg_dat[0];
        end
    end

    // Clearing takes priority over a count in the same cycle
    always_ff @(posedge clk) begin
        if (!n_rst || clr_counts) begin
            commits_q <= '0;
            retries_q <= '0;
        end else if (i_upd_en) begin
            if (i_upd_retry) begin
                retries_q <= retries_q + count_t'(1);
            end else begin
                commits_q <= commits_q + count_t'(1);
            end
        end
    end

endmodule

// ==== sq_store_writer.sv ====
/*
 * Store writer
 * Takes one launched store at a time, runs it as a Wishbone classic write
 * and reports completion or a retry back to the store queue
 */
`timescale 1ns/1ns

module sq_store_writer #(
    parameter int SQ_DEPTH = 8
) (
    input  logic                clk,
    input  logic                n_rst,

    input  logic                i_launch_en,
    input  logic [SQ_DEPTH-1:0] i_launch_sel,
    input  sq_pkg::lsu_func_t   i_launch_func,
    input  sq_pkg::addr_t       i_launch_addr,
    input  sq_pkg::data_t       i_launch_data,
    output logic                o_launch_stall,

    input  logic                i_commit_en,

    output logic                o_upd_en,
    output logic [SQ_DEPTH-1:0] o_upd_sel,
    output logic                o_upd_retry,

    output logic                o_mem_cyc,
    output logic                o_mem_stb,
    output logic                o_mem_we,
    output sq_pkg::addr_t       o_mem_adr,
    output sq_pkg::byte_sel_t   o_mem_sel,
    output sq_pkg::data_t       o_mem_dat,
    input  logic                i_mem_ack,
    input  logic                i_mem_err
);
    import sq_pkg::*;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_BUS,
        WR_REPORT
    } wr_state_t;

    wr_state_t state_q;
    wr_state_t state_d;
    logic      accept;
    logic      bus_end;
    byte_sel_t lane_sel;
    data_t     lane_data;

    // A new store is taken only when idle and commits are enabled
    assign accept         = (state_q == WR_IDLE) & i_launch_en & i_commit_en;
    assign o_launch_stall = (state_q != WR_IDLE) | ~i_commit_en;
    assign bus_end        = (state_q == WR_BUS) & (i_mem_ack | i_mem_err);

    // Byte lanes from store type and address, data copied onto every lane
    always_comb begin
        case (i_launch_func)
            LSU_FUNC_SB: begin
                lane_sel  = byte_sel_t'(4'b0001 << i_launch_addr[1:0]);
                lane_data = {4{i_launch_data[7:0]}};
            end
            LSU_FUNC_SH: begin
                lane_sel  = i_launch_addr[1] ? 4'b1100 : 4'b0011;
                lane_data = {2{i_launch_data[15:0]}};
            end
            default: begin
                lane_sel  = 4'b1111;
                lane_data = i_launch_data;
            end
        endcase
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            WR_IDLE: begin
                if (accept) begin
                    state_d = WR_BUS;
                end
            end
            WR_BUS: begin
                if (bus_end) begin
                    state_d = WR_REPORT;
                end
            end
            // One cycle to hand the result to the queue
            WR_REPORT: state_d = WR_IDLE;
            default:   state_d = WR_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            state_q <= WR_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Bus payload and the entry to report, captured on accept
    always_ff @(posedge clk) begin
        if (accept) begin
            o_mem_adr <= {i_launch_addr[31:2], 2'b00};
            o_mem_sel <= lane_sel;
            o_mem_dat <= lane_data;
            o_upd_sel <= i_launch_sel;
        end
    end

    // An error answer turns the update into a retry
    always_ff @(posedge clk) begin
        if (bus_end) begin
            o_upd_retry <= i_mem_err;
        end
    end

    // cyc and stb rise and fall together, the cycle is always a write
    assign o_mem_cyc = (state_q == WR_BUS);
    assign o_mem_stb = (state_q == WR_BUS);
    assign o_mem_we  = (state_q == WR_BUS);
    assign o_upd_en  = (state_q == WR_REPORT);

endmodule

// ==== sq_store_queue.sv ====
/*
 * Store queue
 * Holds issued stores until the ROB retires them, then launches them one at
 * a time to the bus writer and frees or relaunches them on its update
 */
`timescale 1ns/1ns

module sq_store_queue #(
    parameter int SQ_DEPTH = 8
) (
    input  logic                clk,
    input  logic                n_rst,
    input  logic                i_flush,

    input  logic                i_alloc_en,
    input  sq_pkg::lsu_func_t   i_alloc_func,
    input  sq_pkg::rob_tag_t    i_alloc_tag,
    input  sq_pkg::addr_t       i_alloc_addr,
    input  sq_pkg::data_t       i_alloc_data,
    output logic                o_full,

    input  logic                i_rob_retire_en,
    input  sq_pkg::rob_tag_t    i_rob_retire_tag,
    output logic                o_rob_retire_ack,

    input  logic                i_launch_stall,
    output logic                o_launch_en,
    output logic [SQ_DEPTH-1:0] o_launch_sel,
    output sq_pkg::lsu_func_t   o_launch_func,
    output sq_pkg::addr_t       o_launch_addr,
    output sq_pkg::data_t       o_launch_data,

    input  logic                i_upd_en,
    input  logic [SQ_DEPTH-1:0] i_upd_sel,
    input  logic                i_upd_retry
);
    import sq_pkg::*;

    localparam int IDX_W = $clog2(SQ_DEPTH);

    // Per-entry payload, written once at allocation
    lsu_func_t entry_func_q [SQ_DEPTH];
    rob_tag_t  entry_tag_q  [SQ_DEPTH];
    addr_t     entry_addr_q [SQ_DEPTH];
    data_t     entry_data_q [SQ_DEPTH];

    sq_state_t state_q [SQ_DEPTH];
    sq_state_t state_d [SQ_DEPTH];

    logic [SQ_DEPTH-1:0] empty;
    logic [SQ_DEPTH-1:0] nonspec;
    logic [SQ_DEPTH-1:0] tag_match;
    logic [SQ_DEPTH-1:0] alloc_sel;
    logic [SQ_DEPTH-1:0] rob_sel;
    logic [SQ_DEPTH-1:0] upd_sel;
    logic [SQ_DEPTH-1:0] cancel_sel;
    logic [SQ_DEPTH-1:0] retry_q;
    logic [SQ_DEPTH-1:0] replay_q;
    logic [SQ_DEPTH-1:0] pick_pool;
    logic [SQ_DEPTH-1:0] pick_sel;
    logic                cancel;
    logic                pick_en;
    logic                first_launch;
    logic [IDX_W-1:0]    pick_idx;

    // Isolates the lowest set bit of a vector
    function automatic logic [SQ_DEPTH-1:0] lowest_one(input logic [SQ_DEPTH-1:0] v);
        return v & (~v + 1'b1);
    endfunction

    always_comb begin
        for (int i = 0; i < SQ_DEPTH; i++) begin
            empty[i]     = (state_q[i] == SQ_INVALID);
            nonspec[i]   = (state_q[i] == SQ_NONSPEC);
            tag_match[i] = (entry_tag_q[i] == i_rob_retire_tag);
        end
    end

    assign o_full    = ~|empty;
    assign alloc_sel = i_alloc_en ? lowest_one(empty) : '0;
    // Only an entry still in SQ_VALID reacts to the tag, see the state update
    assign rob_sel   = i_rob_retire_en ? tag_match : '0;
    assign upd_sel   = i_upd_en ? i_upd_sel : '0;

    // A held launch the writer has not taken goes back to SQ_NONSPEC on a
    // flush, and also on a retry so that it cannot pass the failed store
    assign cancel     = o_launch_en & i_launch_stall & (i_flush | (i_upd_en & i_upd_retry));
    assign cancel_sel = cancel ? o_launch_sel : '0;

    // Entry numbers carry no age, so a failed store goes first and a
    // cancelled launch next, ahead of anything retired later
    always_comb begin
        if (|(retry_q & nonspec)) begin
            pick_pool = retry_q & nonspec;
        end else if (|(replay_q & nonspec)) begin
            pick_pool = replay_q & nonspec;
        end else begin
            pick_pool = nonspec;
        end
    end

    assign pick_sel     = i_launch_stall ? '0 : lowest_one(pick_pool);
    assign pick_en      = |pick_sel;
    // Relaunches were acknowledged to the ROB the first time round
    assign first_launch = ~|(pick_sel & (retry_q | replay_q));

    always_comb begin
        pick_idx = '0;
        for (int i = 0; i < SQ_DEPTH; i++) begin
            if (pick_sel[i]) begin
                pick_idx = IDX_W'(i);
            end
        end
    end

    // Next state of every entry
    always_comb begin
        for (int i = 0; i < SQ_DEPTH; i++) begin
            state_d[i] = state_q[i];
            case (state_q[i])
                SQ_INVALID: begin
                    if (alloc_sel[i]) begin
                        state_d[i] = SQ_VALID;
                    end
                end
                SQ_VALID: begin
                    // Flush wins over a retirement in the same cycle
                    if (i_flush) begin
                        state_d[i] = SQ_INVALID;
                    end else if (rob_sel[i]) begin
                        state_d[i] = SQ_NONSPEC;
                    end
                end
                SQ_NONSPEC: begin
                    if (pick_sel[i]) begin
                        state_d[i] = SQ_LAUNCHED;
                    end
                end
                SQ_LAUNCHED: begin
                    if (cancel_sel[i]) begin
                        state_d[i] = SQ_NONSPEC;
                    end else if (upd_sel[i]) begin
                        state_d[i] = i_upd_retry ? SQ_NONSPEC : SQ_INVALID;
                    end
                end
                default: state_d[i] = SQ_INVALID;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < SQ_DEPTH; i++) begin
            if (!n_rst) begin
                state_q[i] <= SQ_INVALID;
            end else begin
                state_q[i] <= state_d[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < SQ_DEPTH; i++) begin
            if (alloc_sel[i]) begin
                entry_func_q[i] <= i_alloc_func;
                entry_tag_q[i]  <= i_alloc_tag;
                entry_addr_q[i] <= i_alloc_addr;
                entry_data_q[i] <= i_alloc_data;
            end
        end
    end

    // Relaunch priority marks, each bit drops once its entry is picked
    always_ff @(posedge clk) begin
        if (!n_rst) begin
            retry_q  <= '0;
            replay_q <= '0;
        end else begin
            retry_q  <= (retry_q & ~pick_sel) | (i_upd_retry ? upd_sel : '0);
            replay_q <= (replay_q & ~pick_sel) | cancel_sel;
        end
    end

    // Launch register, held as long as the writer stalls
    always_ff @(posedge clk) begin
        if (!n_rst) begin
            o_launch_en  <= 1'b0;
            o_launch_sel <= '0;
        end else if (cancel) begin
            o_launch_en <= 1'b0;
        end else if (!i_launch_stall) begin
            o_launch_en  <= pick_en;
            o_launch_sel <= pick_sel;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_launch_stall) begin
            o_launch_func <= entry_func_q[pick_idx];
            o_launch_addr <= entry_addr_q[pick_idx];
            o_launch_data <= entry_data_q[pick_idx];
        end
    end

    // The ROB is released in the cycle after its store is launched
    always_ff @(posedge clk) begin
        if (!n_rst) begin
            o_rob_retire_ack <= 1'b0;
        end else begin
            o_rob_retire_ack <= i_rob_retire_en & pick_en & first_launch &
                                (entry_tag_q[pick_idx] == i_rob_retire_tag);
        end
    end

endmodule

// ==== sq_pkg.sv ====
/*
 * Store-commit shared definitions
 * Bus and field widths, store function codes, the register map of the
 * configuration block and the store-queue entry states
 */
package sq_pkg;

    // Byte address and 32-bit bus data
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;

    // ROB index carried by every store
    typedef logic [4:0] rob_tag_t;

    // Store type, the alignment comes from the low address bits
    typedef logic [1:0] lsu_func_t;

    // Wishbone byte lane select for a 32-bit bus
    typedef logic [3:0] byte_sel_t;

    // Word index on the configuration bus
    typedef logic [1:0] csr_addr_t;

    // Counter width for the commit and retry statistics
    typedef logic [31:0] count_t;

    localparam lsu_func_t LSU_FUNC_SB = 2'b00;
    localparam lsu_func_t LSU_FUNC_SH = 2'b01;
    localparam lsu_func_t LSU_FUNC_SW = 2'b10;

    // Register map, word 3 is reserved and reads zero
    localparam csr_addr_t CSR_CTRL    = 2'd0;
    localparam csr_addr_t CSR_COMMITS = 2'd1;
    localparam csr_addr_t CSR_RETRIES = 2'd2;

    // Life cycle of one queue entry
    typedef enum logic [1:0] {
        SQ_INVALID,
        SQ_VALID,
        SQ_NONSPEC,
        SQ_LAUNCHED
    } sq_state_t;

endpackage
